// ==== src/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

	////////////////////////////////////////////////////////////
	// machine sizes
	////////////////////////////////////////////////////////////
	parameter int XLEN     = 64;	// datapath width
	parameter int ARF_SIZE = 32;	// architectural registers
	parameter int PRF_SIZE = 48;	// physical registers, 16 spare for renaming

	////////////////////////////////////////////////////////////
	// index and data types
	////////////////////////////////////////////////////////////
	typedef logic [$clog2(ARF_SIZE)-1:0] arn_t;	// architectural index
	typedef logic [$clog2(PRF_SIZE)-1:0] prn_t;	// physical tag
	typedef logic [XLEN-1:0]             word_t;	// one data word

	// r31 reads as zero and is never renamed
	parameter arn_t ZERO_REG = arn_t'(31);

endpackage

`default_nettype wire

// ==== src/uop_pkg.sv ====
`default_nettype none

package uop_pkg;
	import core_cfg_pkg::*;

	////////////////////////////////////////////////////////////
	// records on the core boundary
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic            valid;	// decoded instruction present
		logic [XLEN-1:0] pc;	// instruction address
		arn_t            arn_dest;	// ZERO_REG when nothing is written
		arn_t            arn_opa;	// first source
		arn_t            arn_opb;	// second source
	} dispatch_t;

	typedef struct packed {
		logic  valid;	// result on the bus this cycle
		prn_t  tag;	// physical destination of the result
		word_t value;	// result data
	} complete_t;

	typedef struct packed {
		logic            valid;	// one pulse per retired instruction
		logic [XLEN-1:0] pc;	// pc of the retiring instruction
		arn_t            arn_dest;	// architectural destination
		logic            wr_en;	// low for ZERO_REG
		word_t           value;	// architectural result
	} commit_t;

	// reorder buffer slot
	typedef struct packed {
		logic [XLEN-1:0] pc;	// carried to commit
		arn_t            arn_dest;	// carried to commit
		prn_t            prn_dest;	// tag the result lands in
		prn_t            prn_free;	// tag released when this retires
	} rob_entry_t;

endpackage

`default_nettype wire

// ==== src/init_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module init_ctrl (
	input  wire                clock,	// system clock
	input  wire                rst_n,	// sync reset, active low
	output logic               busy,	// holds dispatch off while seeding
	output logic               fill_valid,	// push strobe into free list
	output core_cfg_pkg::prn_t fill_tag	// tag pushed this cycle
);
	import core_cfg_pkg::*;

	typedef enum logic {
		FILL = 1'b0,	// seeding spare tags
		RUN  = 1'b1	// normal operation
	} state_t;

	state_t state;	// current state
	state_t state_next;	// next state
	prn_t   fill_cnt;	// next spare tag starting past the arch set
	logic   fill_last;	// final spare tag going out

	assign fill_last  = (fill_cnt == prn_t'(PRF_SIZE - 1));	// terminal compare
	assign busy       = (state == FILL);
	assign fill_valid = (state == FILL);	// one tag per cycle while filling
	assign fill_tag   = fill_cnt;

	////////////////////////////////////////////////////////////
	// two state machine
	////////////////////////////////////////////////////////////
	always_comb begin
		state_next = state;	// hold by default
		case (state)
			FILL: begin
				if (fill_last) begin
					state_next = RUN;	// last spare tag pushed
				end
			end
			default: state_next = RUN;	// RUN is terminal
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= FILL;
			fill_cnt <= prn_t'(ARF_SIZE);	// tags below are mapped at reset
		end else begin
			state <= state_next;
			if (fill_valid) begin
				fill_cnt <= fill_cnt + 1'b1;	// walk up to PRF_SIZE-1
			end
		end
	end

	// seeding pushes only the spare tags and stops on the last one
	assert property (@(posedge clock) disable iff (!rst_n)
		fill_valid |-> (fill_cnt >= prn_t'(ARF_SIZE)) && (fill_cnt < prn_t'(PRF_SIZE)))
		else $error("init_ctrl fill tag outside the spare range");

endmodule

`default_nettype wire

// ==== src/rename_map.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_map (
	input  wire                     clock,	// system clock
	input  wire                     rst_n,	// sync reset, active low
	input  wire                     accept,	// dispatch taken this cycle
	input  wire core_cfg_pkg::arn_t arn_dest,	// destination to rename
	input  wire core_cfg_pkg::arn_t arn_opa,	// first source lookup
	input  wire core_cfg_pkg::arn_t arn_opb,	// second source lookup
	input  wire core_cfg_pkg::prn_t alloc_tag,	// new tag from free list head
	output core_cfg_pkg::prn_t      opa_tag,	// current mapping of opa
	output core_cfg_pkg::prn_t      opb_tag,	// current mapping of opb
	output core_cfg_pkg::prn_t      prev_tag	// mapping the new tag replaces
);
	import core_cfg_pkg::*;

	prn_t map [ARF_SIZE];	// speculative arch to phys table
	logic dest_wr;	// rename the destination this cycle

	////////////////////////////////////////////////////////////
	// lookups
	////////////////////////////////////////////////////////////
	// reads see the table before this cycle's own update
	assign opa_tag  = map[arn_opa];
	assign opb_tag  = map[arn_opb];
	assign prev_tag = map[arn_dest];	// goes to the ROB as the tag to free

	////////////////////////////////////////////////////////////
	// update
	////////////////////////////////////////////////////////////
	assign dest_wr = accept && (arn_dest != ZERO_REG);	// r31 stays on tag 31

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				map[i] <= prn_t'(i);	// identity map
			end
		end else if (dest_wr) begin
			map[arn_dest] <= alloc_tag;	// youngest writer wins
		end
	end

endmodule

`default_nettype wire

// ==== src/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
	input  wire                     clock,	// system clock
	input  wire                     rst_n,	// sync reset, active low
	input  wire                     fill_valid,	// seed push from init_ctrl
	input  wire core_cfg_pkg::prn_t fill_tag,	// seed tag
	input  wire                     pop,	// dispatch consumes head
	input  wire                     free_valid,	// commit returns a tag
	input  wire core_cfg_pkg::prn_t free_tag,	// returned tag
	output core_cfg_pkg::prn_t      head_tag,	// next tag to hand out
	output logic                    empty	// nothing left to allocate
);
	import core_cfg_pkg::*;

	localparam int CNT_W = $clog2(PRF_SIZE + 1);	// count up to PRF_SIZE

	prn_t             queue [PRF_SIZE];	// tag storage
	prn_t             head;	// oldest free tag
	prn_t             tail;	// next write slot
	logic [CNT_W-1:0] count;	// tags held
	logic             push;	// any write this cycle
	prn_t             push_tag;	// tag being written

	// depth is not a power of two so pointers wrap by compare
	function automatic prn_t ptr_inc(input prn_t ptr);
		return (ptr == prn_t'(PRF_SIZE - 1)) ? prn_t'(0) : ptr + 1'b1;
	endfunction

	assign push     = fill_valid || free_valid;	// seeding and commit never overlap
	assign push_tag = fill_valid ? fill_tag : free_tag;
	assign head_tag = queue[head];	// shown before pop
	assign empty    = (count == '0);

	////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (push) begin
			queue[tail] <= push_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;	// init_ctrl refills after reset
		end else begin
			if (push) begin
				tail <= ptr_inc(tail);
			end
			if (pop) begin
				head <= ptr_inc(head);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// idle or push with pop
			endcase
		end
	end

	// stall in the top level must keep dispatch off an empty list
	assert property (@(posedge clock) disable iff (!rst_n) pop |-> !empty)
		else $error("free_list popped while empty");

	// a tag comes back only after leaving, so the list cannot overfill
	assert property (@(posedge clock) disable iff (!rst_n)
		(push && !pop) |-> (count < CNT_W'(PRF_SIZE)))
		else $error("free_list overflow");

endmodule

`default_nettype wire

// ==== src/phys_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module phys_regfile (
	input  wire                        clock,	// system clock
	input  wire                        rst_n,	// sync reset, active low
	input  wire uop_pkg::complete_t    complete,	// completion bus
	input  wire                        alloc_valid,	// dispatch accepted
	input  wire core_cfg_pkg::prn_t    alloc_tag,	// tag handed to dispatch
	input  wire core_cfg_pkg::prn_t    head_tag,	// ROB head destination
	output logic                       head_ready,	// head result written
	output core_cfg_pkg::word_t        head_value	// head result
);
	import core_cfg_pkg::*;

	word_t               values [PRF_SIZE];	// physical register values
	logic [PRF_SIZE-1:0] ready;	// value valid per tag

	////////////////////////////////////////////////////////////
	// commit read port
	////////////////////////////////////////////////////////////
	assign head_ready = ready[head_tag];	// completion at edge N shows here from N+1
	assign head_value = values[head_tag];

	////////////////////////////////////////////////////////////
	// values
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				values[i] <= '0;	// arch state starts at zero
			end
		end else if (complete.valid) begin
			values[complete.tag] <= complete.value;	// cdb write
		end
	end

	////////////////////////////////////////////////////////////
	// ready bits
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ready <= {{(PRF_SIZE - ARF_SIZE){1'b0}}, {ARF_SIZE{1'b1}}};	// mapped tags ready
		end else begin
			if (alloc_valid) begin
				ready[alloc_tag] <= 1'b0;	// new destination waits for its result
			end
			if (complete.valid) begin
				ready[complete.tag] <= 1'b1;	// result has landed
			end
		end
	end

	// completions only target tags that dispatch handed out and that are still waiting
	assert property (@(posedge clock) disable iff (!rst_n)
		complete.valid |-> !ready[complete.tag])
		else $error("phys_regfile completion on a ready tag");

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = 16	// entries, power of two
) (
	input  wire                     clock,	// system clock
	input  wire                     rst_n,	// sync reset, active low
	input  wire                     accept,	// dispatch taken this cycle
	input  wire uop_pkg::dispatch_t dispatch,	// pc and destination to record
	input  wire core_cfg_pkg::prn_t alloc_tag,	// new destination tag
	input  wire core_cfg_pkg::prn_t prev_tag,	// mapping being replaced
	input  wire                     head_ready,	// head result present
	input  wire core_cfg_pkg::word_t head_value,	// head result
	output logic                    full,	// no room for dispatch
	output core_cfg_pkg::prn_t      head_tag,	// head destination to regfile
	output logic                    free_valid,	// release strobe to free list
	output core_cfg_pkg::prn_t      free_tag,	// tag released on commit
	output uop_pkg::commit_t        commit	// retirement report
);
	import core_cfg_pkg::*;
	import uop_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);	// slot index width

	rob_entry_t     entries [ROB_DEPTH];	// in order record
	logic [IDX_W:0] head_ptr;	// oldest entry, top bit is the lap
	logic [IDX_W:0] tail_ptr;	// next free slot, top bit is the lap
	rob_entry_t     head_entry;	// slot at the head
	rob_entry_t     new_entry;	// slot being written
	logic           empty;	// nothing in flight
	logic           retire;	// head leaves this cycle

	////////////////////////////////////////////////////////////
	// occupancy
	////////////////////////////////////////////////////////////
	assign empty = (head_ptr == tail_ptr);
	assign full  = (head_ptr[IDX_W] != tail_ptr[IDX_W])	// one lap apart
		&& (head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]);

	assign head_entry = entries[head_ptr[IDX_W-1:0]];
	assign head_tag   = head_entry.prn_dest;	// regfile looks up readiness
	assign retire     = !empty && head_ready;	// strictly in order, one per cycle

	////////////////////////////////////////////////////////////
	// dispatch record and commit report
	////////////////////////////////////////////////////////////
	always_comb begin
		new_entry.pc       = dispatch.pc;
		new_entry.arn_dest = dispatch.arn_dest;
		new_entry.prn_dest = alloc_tag;
		// a ZERO_REG result is never visible so its own tag goes back
		new_entry.prn_free = (dispatch.arn_dest == ZERO_REG) ? alloc_tag : prev_tag;
	end

	always_comb begin
		commit.valid    = retire;	// pulse, pops on the same edge
		commit.pc       = head_entry.pc;
		commit.arn_dest = head_entry.arn_dest;
		commit.wr_en    = (head_entry.arn_dest != ZERO_REG);	// no arch write for r31
		commit.value    = head_value;
	end

	assign free_valid = retire;
	assign free_tag   = head_entry.prn_free;	// superseded mapping

	////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept) begin
			entries[tail_ptr[IDX_W-1:0]] <= new_entry;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head_ptr <= '0;
			tail_ptr <= '0;	// empty after reset
		end else begin
			if (accept) begin
				tail_ptr <= tail_ptr + 1'b1;	// wraps with lap bit
			end
			if (retire) begin
				head_ptr <= head_ptr + 1'b1;
			end
		end
	end

	// the top level stall must include full
	assert property (@(posedge clock) disable iff (!rst_n) accept |-> !full)
		else $error("reorder_buffer accept while full");

endmodule

`default_nettype wire

// ==== src/rename_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_core #(
	parameter int ROB_DEPTH = 16	// reorder buffer entries, power of two
) (
	input  wire                     clock,	// system clock
	input  wire                     rst_n,	// sync reset, active low
	input  wire uop_pkg::dispatch_t dispatch,	// one decoded instruction
	input  wire uop_pkg::complete_t complete,	// single cdb from execution
	output logic                    stall,	// dispatch must hold
	output core_cfg_pkg::prn_t      alloc_tag,	// destination tag of this dispatch
	output core_cfg_pkg::prn_t      opa_tag,	// renamed first source
	output core_cfg_pkg::prn_t      opb_tag,	// renamed second source
	output uop_pkg::commit_t        commit	// retirement report
);
	import core_cfg_pkg::*;

	logic  init_busy;	// free list still seeding
	logic  fill_valid;	// seed push
	prn_t  fill_tag;	// seed tag
	logic  fl_empty;	// no tag to allocate
	logic  rob_full;	// no ROB slot
	logic  accept;	// dispatch taken
	prn_t  prev_tag;	// mapping replaced by this dispatch
	prn_t  head_tag;	// ROB head destination
	logic  head_ready;	// head result present
	word_t head_value;	// head result
	logic  free_valid;	// commit releases a tag
	prn_t  free_tag;	// released tag

	assign stall  = init_busy || fl_empty || rob_full;
	assign accept = dispatch.valid && !stall;	// broadcast to every block

	////////////////////////////////////////////////////////////
	// rename front
	////////////////////////////////////////////////////////////
	init_ctrl u_init_ctrl (.clock(clock), .rst_n(rst_n), .busy(init_busy),
		.fill_valid(fill_valid), .fill_tag(fill_tag));

	free_list u_free_list (.clock(clock), .rst_n(rst_n), .fill_valid(fill_valid),
		.fill_tag(fill_tag), .pop(accept), .free_valid(free_valid), .free_tag(free_tag),
		.head_tag(alloc_tag), .empty(fl_empty));

	rename_map u_rename_map (.clock(clock), .rst_n(rst_n), .accept(accept),
		.arn_dest(dispatch.arn_dest), .arn_opa(dispatch.arn_opa), .arn_opb(dispatch.arn_opb),
		.alloc_tag(alloc_tag), .opa_tag(opa_tag), .opb_tag(opb_tag), .prev_tag(prev_tag));

	////////////////////////////////////////////////////////////
	// results and retirement
	////////////////////////////////////////////////////////////
	phys_regfile u_phys_regfile (.clock(clock), .rst_n(rst_n), .complete(complete),
		.alloc_valid(accept), .alloc_tag(alloc_tag), .head_tag(head_tag),
		.head_ready(head_ready), .head_value(head_value));

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (.clock(clock), .rst_n(rst_n),
		.accept(accept), .dispatch(dispatch), .alloc_tag(alloc_tag), .prev_tag(prev_tag),
		.head_ready(head_ready), .head_value(head_value), .full(rob_full),
		.head_tag(head_tag), .free_valid(free_valid), .free_tag(free_tag), .commit(commit));

endmodule

`default_nettype wire

// ==== verification/rename_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb;
	import core_cfg_pkg::*;
	import uop_pkg::*;

	localparam int ROB_DEPTH    = 16;	// passed down to the reorder buffer
	localparam int INIT_CYCLES  = PRF_SIZE - ARF_SIZE;	// free list seeding time
	localparam int RANDOM_COUNT = 240;	// length of the random run

	typedef struct packed {
		logic [XLEN-1:0] pc;	// dispatch pc
		arn_t            arn_dest;	// architectural destination
		prn_t            tag;	// tag the DUT allocated
	} flight_t;	// one in-flight instruction of the model

	logic            clock;
	logic            rst_n;
	dispatch_t       dispatch;	// driven 2 ns after the edge
	complete_t       complete;	// testbench acts as the execution units
	logic            stall;
	prn_t            alloc_tag;
	prn_t            opa_tag;
	prn_t            opb_tag;
	commit_t         commit;

	prn_t            spec_map [ARF_SIZE];	// model rename table
	prn_t            arch_map [ARF_SIZE];	// model retired mapping
	logic            tag_done [PRF_SIZE];	// result landed per tag
	word_t           tag_value [PRF_SIZE];	// value given per tag
	flight_t         flight_q [$];	// model ROB in dispatch order
	prn_t            pending_q [$];	// dispatched but not yet completed
	flight_t         new_flight;	// entry being pushed
	commit_t         exp_commit;	// expected report this cycle
	logic            monitor_on;
	logic            stall_check_on;	// set once seeding is over
	logic [63:0]     rng;	// xorshift state
	logic [XLEN-1:0] next_pc;
	int              sent;	// accepted dispatches
	int              retired;	// observed commits

	rename_core #(.ROB_DEPTH(ROB_DEPTH)) dut (.clock(clock), .rst_n(rst_n),
		.dispatch(dispatch), .complete(complete), .stall(stall), .alloc_tag(alloc_tag),
		.opa_tag(opa_tag), .opb_tag(opb_tag), .commit(commit));

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	////////////////////////////////////////////////////////////
	// helpers and reference model
	////////////////////////////////////////////////////////////
	function automatic logic [63:0] xorshift(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// oldest model entry retires once its result has landed
	function automatic commit_t ref_commit();
		commit_t c;
		c = '0;
		if (flight_q.size() > 0) begin
			if (tag_done[flight_q[0].tag]) begin
				c.valid    = 1'b1;
				c.pc       = flight_q[0].pc;
				c.arn_dest = flight_q[0].arn_dest;
				c.wr_en    = (flight_q[0].arn_dest != ZERO_REG);	// r31 never written
				c.value    = tag_value[flight_q[0].tag];
			end
		end
		return c;
	endfunction

	// ROB full or no spare tag left
	function automatic logic dispatch_blocked();
		return (flight_q.size() >= ROB_DEPTH) || (flight_q.size() >= PRF_SIZE - ARF_SIZE);
	endfunction

	function automatic logic tag_live(input prn_t t);
		logic live;
		live = 1'b0;
		for (int i = 0; i < ARF_SIZE; i++) begin
			if ((spec_map[i] == t) || (arch_map[i] == t)) begin
				live = 1'b1;	// still mapped
			end
		end
		foreach (flight_q[i]) begin
			if (flight_q[i].tag == t) begin
				live = 1'b1;	// still in flight
			end
		end
		return live;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_equal(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// one cycle of stimulus that dispatches only when the core is not stalled
	task automatic issue(input logic want_disp, input logic rand_regs, input arn_t dest,
		input arn_t opa, input arn_t opb, input logic want_comp);
		int idx;
		@(posedge clock);
		#2;
		dispatch = '0;
		complete = '0;
		if (want_disp && !stall) begin
			rng               = xorshift(rng);
			dispatch.valid    = 1'b1;
			dispatch.pc       = next_pc;
			dispatch.arn_dest = rand_regs ? arn_t'(rng[4:0]) : dest;
			dispatch.arn_opa  = rand_regs ? arn_t'(rng[9:5]) : opa;
			dispatch.arn_opb  = rand_regs ? arn_t'(rng[14:10]) : opb;
			next_pc           = next_pc + 4;
			sent++;
		end
		if (want_comp && (pending_q.size() > 0)) begin
			rng            = xorshift(rng);
			idx            = int'(rng[15:0]) % pending_q.size();	// random completion order
			complete.valid = 1'b1;
			complete.tag   = pending_q[idx];
			rng            = xorshift(rng);
			complete.value = rng;
			pending_q.delete(idx);
		end
	endtask

	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while ((flight_q.size() > 0) || (pending_q.size() > 0)) begin
			issue(1'b0, 1'b0, '0, '0, '0, 1'b1);
			cycles++;
			if (cycles > limit) begin
				fail_run("timeout while waiting for the ROB to drain");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// compare process samples outputs at the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (monitor_on) begin
			exp_commit = ref_commit();
			check_equal("commit.valid", 64'(commit.valid), 64'(exp_commit.valid));
			if (exp_commit.valid) begin
				check_equal("commit.pc", commit.pc, exp_commit.pc);
				check_equal("commit.arn_dest", 64'(commit.arn_dest), 64'(exp_commit.arn_dest));
				check_equal("commit.wr_en", 64'(commit.wr_en), 64'(exp_commit.wr_en));
				check_equal("commit.value", commit.value, exp_commit.value);
			end
			if (commit.valid) begin
				retired++;	// pulses seen on the DUT port
			end
			if (stall_check_on) begin
				check_equal("stall", 64'(stall), 64'(dispatch_blocked()));
			end
			if (dispatch.valid && !stall) begin
				check_equal("opa_tag", 64'(opa_tag), 64'(spec_map[dispatch.arn_opa]));
				check_equal("opb_tag", 64'(opb_tag), 64'(spec_map[dispatch.arn_opb]));
				if (tag_live(alloc_tag)) begin
					fail_run($sformatf("alloc_tag 0x%h handed out while still in use", alloc_tag));
				end
			end
			// model updates land at the coming edge
			if (exp_commit.valid) begin
				if (flight_q[0].arn_dest != ZERO_REG) begin
					arch_map[flight_q[0].arn_dest] = flight_q[0].tag;
				end
				void'(flight_q.pop_front());
			end
			if (dispatch.valid && !stall) begin
				if (dispatch.arn_dest != ZERO_REG) begin
					spec_map[dispatch.arn_dest] = alloc_tag;	// youngest writer
				end
				new_flight.pc       = dispatch.pc;
				new_flight.arn_dest = dispatch.arn_dest;
				new_flight.tag      = alloc_tag;
				tag_done[alloc_tag] = 1'b0;
				flight_q.push_back(new_flight);
				pending_q.push_back(alloc_tag);
			end
			if (complete.valid) begin
				tag_done[complete.tag]  = 1'b1;
				tag_value[complete.tag] = complete.value;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin
		int cycles;
		int target;
		rst_n          = 1'b0;
		dispatch       = '0;
		complete       = '0;
		monitor_on     = 1'b0;
		stall_check_on = 1'b0;
		rng            = 64'd90589;	// fixed seed
		next_pc        = 64'h1000;
		sent           = 0;
		retired        = 0;
		for (int i = 0; i < ARF_SIZE; i++) begin
			spec_map[i] = prn_t'(i);	// identity after reset
			arch_map[i] = prn_t'(i);
		end
		for (int i = 0; i < PRF_SIZE; i++) begin
			tag_done[i]  = 1'b0;
			tag_value[i] = '0;
		end
		repeat (8) @(posedge clock);
		#2;
		rst_n      = 1'b1;
		monitor_on = 1'b1;

		// seeding holds dispatch off for a fixed time
		cycles = 0;
		check_equal("stall", 64'(stall), 64'd1);
		while (stall) begin
			@(posedge clock);
			#2;
			cycles++;
			check_equal("commit.valid", 64'(commit.valid), 64'd0);
			if (cycles > INIT_CYCLES + 4) begin
				fail_run("stall did not fall after free list seeding");
			end
		end
		check_equal("init stall cycles", 64'(cycles), 64'(INIT_CYCLES));
		stall_check_on = 1'b1;

		// zero register destination then a read of r31
		issue(1'b1, 1'b0, ZERO_REG, arn_t'(1), arn_t'(2), 1'b0);
		issue(1'b1, 1'b0, arn_t'(5), ZERO_REG, ZERO_REG, 1'b0);
		@(negedge clock);
		check_equal("dispatch accepted", 64'(dispatch.valid && !stall), 64'd1);
		check_equal("opa_tag", 64'(opa_tag), 64'd31);
		wait_drain(50);

		// fill the ROB without completing anything
		target = sent + ROB_DEPTH;
		cycles = 0;
		while (sent < target) begin
			issue(1'b1, 1'b1, '0, '0, '0, 1'b0);
			cycles++;
			if (cycles > ROB_DEPTH + 8) begin
				fail_run("ROB did not take ROB_DEPTH instructions");
			end
		end
		cycles = 0;
		while (!stall) begin
			issue(1'b0, 1'b0, '0, '0, '0, 1'b0);
			cycles++;
			if (cycles > 4) begin
				fail_run("stall did not rise with a full ROB");
			end
		end
		repeat (3) issue(1'b1, 1'b1, '0, '0, '0, 1'b0);	// held off by stall
		check_equal("stall", 64'(stall), 64'd1);	// nothing retired so still full
		wait_drain(200);

		// long random run exercises tag recycling
		target = sent + RANDOM_COUNT;
		cycles = 0;
		while (sent < target) begin
			rng = xorshift(rng);
			issue(rng[0] | rng[1], 1'b1, '0, '0, '0, rng[2] | rng[3]);
			cycles++;
			if (cycles > 20 * RANDOM_COUNT) begin
				fail_run("random run did not dispatch enough instructions");
			end
		end
		wait_drain(400);
		check_equal("retired", 64'(retired), 64'(sent));
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
src/core_cfg_pkg.sv
src/uop_pkg.sv
src/init_ctrl.sv
src/rename_map.sv
src/free_list.sv
src/phys_regfile.sv
src/reorder_buffer.sv
src/rename_core.sv
verification/rename_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rename_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module rename_core_tb -f files.f \
	--Mdir obj_dir -o rename_core_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/rename_core_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit "$status"
fi

echo "simulation exited cleanly"
exit 0
